// File: list.f
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_sample_if.sv
verilog/spi_sampler.sv
verilog/register_bank.sv
verilog/spi_mux.sv
verilog/top.sv
test/tb_top.sv

// File: run.sh
#!/bin/sh
# build the spi link testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_top -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_top 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the run only counts as passed if the testbench printed its pass line
if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: test/tb_top.sv
/*
  testbench for the spi board-control link
  spi master tasks, register model, routing checks, watchdog
*/
`include "spi_config.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  // spi half period in clk cycles
  localparam int HALF_CYCLES = 8;
  localparam int NUM_FRAMES = 27;
  localparam int WATCHDOG_CYCLES =
    NUM_FRAMES * (`SPI_FRAME_BITS + 2) * 2 * HALF_CYCLES + 1000;
  localparam spi_pkg::periph_mask_t CS_IDLE = ~`SPI_CS_POLARITY;
  localparam spi_pkg::reg_addr_t ADDR_UNKNOWN = 8'h3C;

  logic clk, rst_n;
  logic spi_clk, spi_cs, spi_cs2, spi_mosi, spi_miso;
  logic led0, glb_4094_oe;
  spi_pkg::periph_mask_t periph_miso, periph_cs, periph_clk, periph_mosi;
  logic [6:0] mon;
  integer seed;
  // clk cycles with both selects idle, saturating
  logic [3:0] idle_cnt;

  // register model
  logic [3:0] exp_led;
  logic [3:0] exp_4094;
  spi_pkg::periph_mask_t exp_mask;
  spi_pkg::reg_word_t rdata;

  top top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .spi_clk     (spi_clk),
    .spi_cs      (spi_cs),
    .spi_cs2     (spi_cs2),
    .spi_mosi    (spi_mosi),
    .spi_miso    (spi_miso),
    .led0        (led0),
    .glb_4094_oe (glb_4094_oe),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .periph_clk  (periph_clk),
    .periph_mosi (periph_mosi),
    .mon         (mon)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////

  task automatic fail_value(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else fail_value(name, got, exp);
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_cnt <= 4'd0;
    end else if (spi_cs && spi_cs2) begin
      if (idle_cnt != 4'hF) begin
        idle_cnt <= idle_cnt + 4'd1;
      end
    end else begin
      idle_cnt <= 4'd0;
    end
  end

  // a few cycles after both selects go high the bus is fully idle
  a_idle_miso : assert property (@(posedge clk) disable iff (!rst_n)
    (idle_cnt >= 4'd4) |-> !spi_miso)
    else fail_value("spi_miso", 32'(spi_miso), 32'h0);

  a_idle_cs : assert property (@(posedge clk) disable iff (!rst_n)
    (idle_cnt >= 4'd4) |-> (periph_cs == CS_IDLE))
    else fail_value("periph_cs", 32'(periph_cs), 32'(CS_IDLE));

  // monitor header mirrors the raw pins
  a_mon : assert property (@(posedge clk) disable iff (!rst_n)
    mon == {2'b00, glb_4094_oe, spi_miso, spi_mosi, spi_clk, spi_cs})
    else fail_value("mon", 32'(mon), 32'({2'b00, glb_4094_oe, spi_miso, spi_mosi,
                                          spi_clk, spi_cs}));

  // routed lines follow the bus, unrouted lines stay parked
  task automatic check_routing();
    spi_pkg::periph_mask_t exp_cs, exp_clk, exp_mosi;
    if (!spi_cs2) begin
      exp_cs   = (`SPI_CS_POLARITY & exp_mask) | (CS_IDLE & ~exp_mask);
      exp_clk  = spi_clk ? exp_mask : '0;
      exp_mosi = spi_mosi ? exp_mask : '0;
      check_value("periph_cs", 32'(periph_cs), 32'(exp_cs));
      check_value("periph_clk", 32'(periph_clk), 32'(exp_clk));
      check_value("periph_mosi", 32'(periph_mosi), 32'(exp_mosi));
      check_value("spi_miso", 32'(spi_miso), 32'(|(periph_miso & exp_mask)));
    end
  endtask

  //////////////////////////////////////////////////
  // spi master
  //////////////////////////////////////////////////

  // new peripheral data each half, routing checked at mid point
  task automatic half_period();
    periph_miso = 8'($random(seed));
    repeat (HALF_CYCLES / 2) @(negedge clk);
    check_routing();
    repeat (HALF_CYCLES / 2) @(negedge clk);
  endtask

  // mode 0 frame, address then data msb first, extra bits are zero
  task automatic spi_frame(input logic use_cs2, input spi_pkg::reg_addr_t addr,
                           input spi_pkg::reg_word_t data, input int nbits,
                           output spi_pkg::reg_word_t miso_word);
    logic [`SPI_FRAME_BITS-1:0] frame;
    frame = {addr, data};
    miso_word = '0;
    if (use_cs2) begin
      spi_cs2 = 1'b0;
    end else begin
      spi_cs = 1'b0;
    end
    half_period();
    for (int i = 0; i < nbits; i++) begin
      spi_mosi = (i < `SPI_FRAME_BITS) ? frame[`SPI_FRAME_BITS-1-i] : 1'b0;
      half_period();
      // miso taken just before the rising edge
      if (!use_cs2 && i < `SPI_ADDR_BITS) begin
        check_value("spi_miso", 32'(spi_miso), 32'h0);
      end else if (i >= `SPI_ADDR_BITS && i < `SPI_FRAME_BITS) begin
        miso_word = {miso_word[`SPI_DATA_BITS-2:0], spi_miso};
      end
      spi_clk = 1'b1;
      half_period();
      spi_clk = 1'b0;
    end
    half_period();
    spi_cs   = 1'b1;
    spi_cs2  = 1'b1;
    spi_mosi = 1'b0;
    half_period();
  endtask

  //////////////////////////////////////////////////
  // register model
  //////////////////////////////////////////////////

  function automatic spi_pkg::reg_word_t expected_read(input spi_pkg::reg_addr_t addr);
    case (addr)
      `REG_ADDR_ID:      return `REG_ID_VALUE;
      `REG_ADDR_LED:     return {12'h000, exp_led};
      `REG_ADDR_SPI_MUX: return {8'h00, exp_mask};
      `REG_ADDR_4094:    return {12'h000, exp_4094};
      default:           return '0;
    endcase
  endfunction

  // one bank frame reads the old value and, if complete, writes the new one
  task automatic access_reg(input spi_pkg::reg_addr_t addr, input spi_pkg::reg_word_t data,
                            input int nbits);
    spi_pkg::reg_word_t old_value;
    old_value = expected_read(addr);
    spi_frame(1'b0, addr, data, nbits, rdata);
    if (nbits >= `SPI_FRAME_BITS) begin
      check_value("read data", 32'(rdata), 32'(old_value));
    end
    if (nbits == `SPI_FRAME_BITS) begin
      case (addr)
        `REG_ADDR_LED:     exp_led  = data[3:0];
        `REG_ADDR_SPI_MUX: exp_mask = data[`SPI_PERIPH_COUNT-1:0];
        `REG_ADDR_4094:    exp_4094 = data[3:0];
        default:           ;
      endcase
    end
    check_value("led0", 32'(led0), 32'(exp_led[0]));
    check_value("glb_4094_oe", 32'(glb_4094_oe), 32'(exp_4094[0]));
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    seed        = 91368;
    rst_n       = 1'b0;
    spi_clk     = 1'b0;
    spi_cs      = 1'b1;
    spi_cs2     = 1'b1;
    spi_mosi    = 1'b0;
    periph_miso = '0;
    exp_led     = '0;
    exp_4094    = '0;
    exp_mask    = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (HALF_CYCLES) @(negedge clk);

    // reset state
    check_value("led0", 32'(led0), 32'h0);
    check_value("glb_4094_oe", 32'(glb_4094_oe), 32'h0);
    check_value("periph_cs", 32'(periph_cs), 32'(CS_IDLE));
    check_value("spi_miso", 32'(spi_miso), 32'h0);

    // random writes, each read back as the old value of the next frame
    for (int r = 0; r < 4; r++) begin
      access_reg(`REG_ADDR_LED, 16'($random(seed)), `SPI_FRAME_BITS);
      access_reg(`REG_ADDR_SPI_MUX, 16'($random(seed)), `SPI_FRAME_BITS);
      access_reg(`REG_ADDR_4094, 16'($random(seed)), `SPI_FRAME_BITS);
    end

    // id is read only, unknown address reads zero
    access_reg(`REG_ADDR_ID, 16'($random(seed)), `SPI_FRAME_BITS);
    access_reg(`REG_ADDR_ID, 16'($random(seed)), `SPI_FRAME_BITS);
    access_reg(ADDR_UNKNOWN, 16'($random(seed)), `SPI_FRAME_BITS);
    access_reg(ADDR_UNKNOWN, 16'($random(seed)), `SPI_FRAME_BITS);

    // short and long frames are dropped
    access_reg(`REG_ADDR_LED, 16'($random(seed)), 15);
    access_reg(`REG_ADDR_LED, 16'($random(seed)), `SPI_FRAME_BITS);
    access_reg(`REG_ADDR_4094, 16'($random(seed)), `SPI_FRAME_BITS + 1);
    access_reg(`REG_ADDR_4094, 16'($random(seed)), `SPI_FRAME_BITS);
    access_reg(`REG_ADDR_SPI_MUX, 16'($random(seed)), `SPI_FRAME_BITS);

    // second select pass-through with fresh masks
    for (int r = 0; r < 3; r++) begin
      access_reg(`REG_ADDR_SPI_MUX, 16'($random(seed)), `SPI_FRAME_BITS);
      spi_frame(1'b1, 8'($random(seed)), 16'($random(seed)), `SPI_FRAME_BITS, rdata);
    end

    $display("Everything OK");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the test sequence finished");
    $display("Something failed");
    $fatal(1);
  end

endmodule

// File: verilog/register_bank.sv
/*
  spi slave register bank on the first chip select
  address/data shift-in, old-value shift-out, write commit, control registers
*/
`include "spi_config.svh"

module register_bank (
  input  logic                  clk,
  input  logic                  rst_n,
  spi_sample_if.dst             smp,
  output logic                  bank_miso,
  output logic [3:0]            reg_led,
  output spi_pkg::periph_mask_t spi_mask,
  output logic [3:0]            reg_4094
);

  // counter holds 0..24 plus one overrun value
  localparam int CNT_BITS = $clog2(`SPI_FRAME_BITS + 2);
  localparam logic [CNT_BITS-1:0] ADDR_CNT = CNT_BITS'(`SPI_ADDR_BITS);
  localparam logic [CNT_BITS-1:0] FRAME_CNT = CNT_BITS'(`SPI_FRAME_BITS);
  localparam logic [CNT_BITS-1:0] OVER_CNT = FRAME_CNT + 1'b1;

  logic [CNT_BITS-1:0]        bit_cnt;
  logic [`SPI_FRAME_BITS-1:0] shift_in;
  spi_pkg::reg_word_t         shift_out;
  spi_pkg::reg_addr_t         rd_addr;
  spi_pkg::reg_addr_t         wr_addr;
  spi_pkg::reg_word_t         wr_data;
  logic                       rise_in_frame;
  logic                       fall_in_frame;
  logic                       data_phase;

  // register read-back where unknown addresses read as zero
  function automatic spi_pkg::reg_word_t read_reg(input spi_pkg::reg_addr_t addr);
    case (addr)
      `REG_ADDR_ID:      return `REG_ID_VALUE;
      `REG_ADDR_LED:     return spi_pkg::reg_word_t'(reg_led);
      `REG_ADDR_SPI_MUX: return spi_pkg::reg_word_t'(spi_mask);
      `REG_ADDR_4094:    return spi_pkg::reg_word_t'(reg_4094);
      default:           return '0;
    endcase
  endfunction

  assign rise_in_frame = smp.sclk_rise & smp.sel;
  assign fall_in_frame = smp.sclk_fall & smp.sel;

  // the 8th bit completes the address together with the current mosi
  assign rd_addr = {shift_in[`SPI_ADDR_BITS-2:0], smp.mosi};

  // after a full frame the address sits on top of the shift register
  assign wr_addr = shift_in[`SPI_FRAME_BITS-1 -: `SPI_ADDR_BITS];
  assign wr_data = shift_in[`SPI_DATA_BITS-1:0];

  // bits 8..23 have been counted, so the next fall drives a data bit
  assign data_phase = (bit_cnt >= ADDR_CNT) && (bit_cnt < FRAME_CNT);

  //////////////////////////////////////////////////
  // shift registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rise_in_frame) begin
      shift_in <= {shift_in[`SPI_FRAME_BITS-2:0], smp.mosi};
    end
    // snapshot the old value at the 8th rise, then walk it out msb first
    if (rise_in_frame && (bit_cnt == ADDR_CNT - 1'b1)) begin
      shift_out <= read_reg(rd_addr);
    end else if (fall_in_frame && data_phase) begin
      shift_out <= {shift_out[`SPI_DATA_BITS-2:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////
  // bit counter and miso
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt   <= '0;
      bank_miso <= 1'b0;
    end else begin
      if (smp.sel_end) begin
        bit_cnt <= '0;
      end else if (rise_in_frame && (bit_cnt != OVER_CNT)) begin
        // saturate one past a frame so long frames stay rejected
        bit_cnt <= bit_cnt + 1'b1;
      end

      // miso stays low in the address phase and outside frames
      if (!smp.sel) begin
        bank_miso <= 1'b0;
      end else if (smp.sclk_fall) begin
        bank_miso <= data_phase ? shift_out[`SPI_DATA_BITS-1] : 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////

  // commit only a frame of exactly 24 bits while id and unknown addresses ignore it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_led  <= '0;
      spi_mask <= '0;
      reg_4094 <= '0;
    end else if (smp.sel_end && (bit_cnt == FRAME_CNT)) begin
      case (wr_addr)
        `REG_ADDR_LED:     reg_led  <= wr_data[3:0];
        `REG_ADDR_SPI_MUX: spi_mask <= wr_data[`SPI_PERIPH_COUNT-1:0];
        `REG_ADDR_4094:    reg_4094 <= wr_data[3:0];
        default:           ;
      endcase
    end
  end

  // an overrun count only lives inside a frame and is gone once sel_end has cleared it
  a_cnt_bounded : assert property (@(posedge clk) disable iff (!rst_n)
    (bit_cnt > FRAME_CNT) |-> smp.sel || $past(smp.sel) || smp.sel_end);

  // miso carries data only after the address is complete and within a frame
  a_miso_idle : assert property (@(posedge clk) disable iff (!rst_n)
    bank_miso |-> (bit_cnt >= ADDR_CNT) && (smp.sel || $past(smp.sel)));

endmodule

// File: verilog/spi_config.svh
/*
  sizing macros for the spi board-control link
  frame layout, register map, identity constant and routed cs polarity
*/
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// frame is address msb first, then data msb first
`define SPI_ADDR_BITS 8
`define SPI_DATA_BITS 16
`define SPI_FRAME_BITS 24

// downstream lines behind the second chip select
`define SPI_PERIPH_COUNT 8
// line 0 is the 4094 strobe and idles low, the rest idle high
`define SPI_CS_POLARITY 8'b00000001

// register map seen over the first chip select
`define REG_ADDR_ID 8'h00
`define REG_ADDR_LED 8'h07
`define REG_ADDR_SPI_MUX 8'h08
`define REG_ADDR_4094 8'h09
`define REG_ID_VALUE 16'h00A5

`endif

// File: verilog/spi_mux.sv
/*
  spi pass-through on the second chip select
  per-line routing with cs polarity, miso source select
*/
`include "spi_config.svh"

module spi_mux (
  input  logic                  clk,
  input  logic                  rst_n,
  spi_sample_if.dst             smp,
  input  spi_pkg::periph_mask_t spi_mask,
  input  logic                  bank_miso,
  input  spi_pkg::periph_mask_t periph_miso,
  output spi_pkg::periph_mask_t periph_cs,
  output spi_pkg::periph_mask_t periph_clk,
  output spi_pkg::periph_mask_t periph_mosi,
  output logic                  spi_miso
);

  // active level of each routed chip select
  localparam spi_pkg::periph_mask_t CS_ACTIVE = `SPI_CS_POLARITY;

  // lines that currently own the bus
  spi_pkg::periph_mask_t route;
  // returning data from the routed lines only
  spi_pkg::periph_mask_t miso_masked;

  assign route       = smp.sel2 ? spi_mask : '0;
  assign miso_masked = periph_miso & spi_mask;

  //////////////////////////////////////////////////
  // outbound lines
  //////////////////////////////////////////////////

  // registered so a pin change reaches the peripherals in 3 cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      periph_cs   <= ~CS_ACTIVE;
      periph_clk  <= '0;
      periph_mosi <= '0;
    end else begin
      for (int i = 0; i < `SPI_PERIPH_COUNT; i++) begin
        if (route[i]) begin
          periph_cs[i]   <= CS_ACTIVE[i];
          periph_clk[i]  <= smp.sclk;
          periph_mosi[i] <= smp.mosi;
        end else begin
          // idle line keeps cs inactive and the bus parked low
          periph_cs[i]   <= ~CS_ACTIVE[i];
          periph_clk[i]  <= 1'b0;
          periph_mosi[i] <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // miso select
  //////////////////////////////////////////////////

  // bank owns miso on the first select, routed peripherals on the second
  always_comb begin
    if (smp.sel) begin
      spi_miso = bank_miso;
    end else if (smp.sel2) begin
      spi_miso = |miso_masked;
    end else begin
      spi_miso = 1'b0;
    end
  end

  // the mask only changes between second-select frames so no line flips cs mid-frame
  a_cs_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (smp.sel2 && $past(smp.sel2)) |-> $stable(spi_mask));

endmodule

// File: verilog/spi_pkg.sv
/*
  types shared by the spi link rtl and its testbench
  register address, register word and per-peripheral mask
*/
`include "spi_config.svh"

package spi_pkg;

  //////////////////////////////////////////////////
  // register bank types
  //////////////////////////////////////////////////

  // address field of a frame
  typedef logic [`SPI_ADDR_BITS-1:0] reg_addr_t;

  // data field of a frame, also the read-back width
  typedef logic [`SPI_DATA_BITS-1:0] reg_word_t;

  //////////////////////////////////////////////////
  // routing types
  //////////////////////////////////////////////////

  // one bit per downstream peripheral
  // used for the routing mask and for the cs/clk/mosi/miso vectors
  typedef logic [`SPI_PERIPH_COUNT-1:0] periph_mask_t;

endpackage

// File: verilog/spi_sample_if.sv
/*
  synchronized spi bus as seen in the clk domain
  levels plus one-cycle edge and select-end pulses
*/
interface spi_sample_if;

  // levels, two clk cycles behind the pins
  logic sclk;
  logic mosi;
  // selects, active high here although the pins are active low
  logic sel;
  logic sel2;

  // single-cycle pulses, one cycle behind the levels
  logic sclk_rise;
  logic sclk_fall;
  logic sel_end;

  // sampler side
  modport src (output sclk, mosi, sel, sel2, sclk_rise, sclk_fall, sel_end);

  // register bank and mux side
  modport dst (input sclk, mosi, sel, sel2, sclk_rise, sclk_fall, sel_end);

endinterface

// File: verilog/spi_sampler.sv
/*
  spi pin sampler
  two-flop synchronizers, edge and select-end pulses, exclusive-select check
*/
module spi_sampler (
  input  logic clk,
  input  logic rst_n,
  input  logic spi_clk,
  input  logic spi_cs,
  input  logic spi_cs2,
  input  logic spi_mosi,
  spi_sample_if.src smp
);

  // pin order in the sync vectors
  // bit 0 sclk, bit 1 cs, bit 2 cs2, bit 3 mosi
  localparam logic [3:0] PIN_IDLE = 4'b0110;

  logic [3:0] pins;
  logic [3:0] sync1;
  logic [3:0] sync2;
  // previous synchronized sclk and cs for edge detect
  logic       sclk_prev;
  logic       cs_prev;

  assign pins = {spi_mosi, spi_cs2, spi_cs, spi_clk};

  //////////////////////////////////////////////////
  // synchronizers
  //////////////////////////////////////////////////

  // both selects reset to their idle high level so nothing looks selected
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync1 <= PIN_IDLE;
      sync2 <= PIN_IDLE;
    end else begin
      sync1 <= pins;
      sync2 <= sync1;
    end
  end

  // levels straight off the second stage
  assign smp.sclk = sync2[0];
  assign smp.sel  = ~sync2[1];
  assign smp.sel2 = ~sync2[2];
  assign smp.mosi = sync2[3];

  //////////////////////////////////////////////////
  // edge pulses
  //////////////////////////////////////////////////

  // registered, so each pulse lands one cycle after its level change
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_prev     <= 1'b0;
      cs_prev       <= 1'b1;
      smp.sclk_rise <= 1'b0;
      smp.sclk_fall <= 1'b0;
      smp.sel_end   <= 1'b0;
    end else begin
      sclk_prev     <= sync2[0];
      cs_prev       <= sync2[1];
      smp.sclk_rise <= sync2[0] & ~sclk_prev;
      smp.sclk_fall <= ~sync2[0] & sclk_prev;
      // cs pin going high ends the bank frame
      smp.sel_end   <= sync2[1] & ~cs_prev;
    end
  end

  // the mcu never drives both chip selects at once
  a_sel_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
    !(smp.sel && smp.sel2));

endmodule

// File: verilog/top.sv
/*
  fpga side of the spi board-control link
  pin sampler, register bank, peripheral mux and monitor outputs
*/
`include "spi_config.svh"

module top (
  input  logic                         clk,
  input  logic                         rst_n,
  // spi from the mcu
  input  logic                         spi_clk,
  input  logic                         spi_cs,
  input  logic                         spi_cs2,
  input  logic                         spi_mosi,
  output logic                         spi_miso,
  // board controls
  output logic                         led0,
  output logic                         glb_4094_oe,
  // routed peripherals, line 0 is the 4094 chain
  input  logic [`SPI_PERIPH_COUNT-1:0] periph_miso,
  output logic [`SPI_PERIPH_COUNT-1:0] periph_cs,
  output logic [`SPI_PERIPH_COUNT-1:0] periph_clk,
  output logic [`SPI_PERIPH_COUNT-1:0] periph_mosi,
  // scope header
  output logic [6:0]                   mon
);

  spi_sample_if smp ();

  logic                  bank_miso;
  logic [3:0]            reg_led;
  logic [3:0]            reg_4094;
  spi_pkg::periph_mask_t spi_mask;

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////

  spi_sampler sampler_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi_clk  (spi_clk),
    .spi_cs   (spi_cs),
    .spi_cs2  (spi_cs2),
    .spi_mosi (spi_mosi),
    .smp      (smp.src)
  );

  register_bank bank_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .smp       (smp.dst),
    .bank_miso (bank_miso),
    .reg_led   (reg_led),
    .spi_mask  (spi_mask),
    .reg_4094  (reg_4094)
  );

  spi_mux mux_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .smp         (smp.dst),
    .spi_mask    (spi_mask),
    .bank_miso   (bank_miso),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .periph_clk  (periph_clk),
    .periph_mosi (periph_mosi),
    .spi_miso    (spi_miso)
  );

  // only bit 0 of each control register reaches a pin
  assign led0        = reg_led[0];
  assign glb_4094_oe = reg_4094[0];

  // raw pins on the monitor so the scope sees the bus unsynchronized
  assign mon = {2'b00, glb_4094_oe, spi_miso, spi_mosi, spi_clk, spi_cs};

endmodule
